// ==== bench/aes_tests.txt ====
# columns: test name, key, plaintext, expected ciphertext
# all values are 128-bit hex with byte 0 first
fips197_appendix_b 2b7e151628aed2a6abf7158809cf4f3c 3243f6a8885a308d313198a2e0370734 3925841d02dc09fbdc118597196a0b32
fips197_appendix_c1 000102030405060708090a0b0c0d0e0f 00112233445566778899aabbccddeeff 69c4e0d86a7b0430d8cdb78070b4c55a
zero_key_zero_text 00000000000000000000000000000000 00000000000000000000000000000000 66e94bd4ef8a2c3b884cfa59ca342b2e
zero_key_ones_text 00000000000000000000000000000000 ffffffffffffffffffffffffffffffff 3f5b8cc9ea855a0afa7347d23e8d664e
ones_key_zero_text ffffffffffffffffffffffffffffffff 00000000000000000000000000000000 a1f6258c877d5fcd8964484538bfc92c

// ==== tb.f ====
+incdir+src
src/AESDefinitions.sv
src/SubstituteByte.sv
src/ExpandKey.sv
src/EncryptRound.sv
src/AESCore.sv
src/AESControlRegs.sv
src/AESTop.sv
bench/AESTop_props.sv
bench/AESTop_tb.sv

// ==== Bender.yml ====
package:
  name: aes_peripheral

export_include_dirs:
  - src

sources:
  - files:
      - src/AESDefinitions.sv
      - src/SubstituteByte.sv
      - src/ExpandKey.sv
      - src/EncryptRound.sv
      - src/AESCore.sv
      - src/AESControlRegs.sv
      - src/AESTop.sv
  - target: test
    files:
      - bench/AESTop_props.sv
      - bench/AESTop_tb.sv

// ==== bench/AESTop_tb.sv ====
/*
 * AESTop testbench that runs the file-driven vectors through the AXI4-Lite
 * register block and checks responses, readback, busy errors and ciphertext
 */
`timescale 1ns/100ps
`default_nettype none

`include "aes_macros.svh"

module AESTop_tb import AESDefinitions::*; ();

    typedef logic [`AXI_DATA_WIDTH-1:0] word_t;

    logic         clk;
    logic         reset;
    axiLiteReq_t  axiRequest;
    axiLiteResp_t axiResponse;

    int     seed;
    int     numTests;
    string  testNames[$];
    block_t testKeys[$];
    block_t testTexts[$];
    block_t testCiphers[$];

    AESTop dut (
        .clk        (clk),
        .reset      (reset),
        .axiRequest (axiRequest),
        .axiResponse(axiResponse)
    );

    initial
    begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic abortRun();
        $display("Verification failed");
        $fatal(1);
    endtask

    task automatic compareBlock(input string name, input block_t expected, input block_t actual);
        if (actual !== expected)
        begin
            $display("Error: %s expected %h actual %h", name, expected, actual);
            abortRun();
        end
    endtask

    task automatic compareResp(input string name, input axiResp_t expected,
                               input axiResp_t actual);
        if (actual !== expected)
        begin
            $display("Error: %s expected %b (%s) actual %b (%s)", name, expected,
                     expected.name(), actual, actual.name());
            abortRun();
        end
    endtask

    task automatic compareWord(input string name, input word_t expected, input word_t actual);
        if (actual !== expected)
        begin
            $display("Error: %s expected %h actual %h", name, expected, actual);
            abortRun();
        end
    endtask

    // a master that is slow to take its responses
    task automatic waitRandom();
        int cycles;
        cycles = $unsigned($random(seed)) % 4;
        repeat (cycles) @(posedge clk);
    endtask

    // the task is called right after a rising edge and returns right after the B handshake edge
    task automatic writeReg(input logic [7:0] addr, input word_t data, input logic [3:0] strb,
                            input bit quick, output axiResp_t resp);
        axiRequest.awAddr  <= addr;
        axiRequest.wData   <= data;
        axiRequest.wStrb   <= strb;
        axiRequest.awValid <= 1'b1;
        axiRequest.wValid  <= 1'b1;
        do
        begin
            @(posedge clk);
        end
        while (!axiResponse.awReady);
        if (axiResponse.wReady !== 1'b1)
        begin
            $display("Write data was not accepted together with the write address at %h", addr);
            abortRun();
        end
        axiRequest.awValid <= 1'b0;
        axiRequest.wValid  <= 1'b0;
        if (!quick)
        begin
            waitRandom();
        end
        axiRequest.bReady <= 1'b1;
        do
        begin
            @(posedge clk);
        end
        while (!axiResponse.bValid);
        resp = axiResponse.bResp;
        axiRequest.bReady <= 1'b0;
    endtask

    task automatic readReg(input logic [7:0] addr, input bit quick, output word_t data,
                           output axiResp_t resp);
        axiRequest.arAddr  <= addr;
        axiRequest.arValid <= 1'b1;
        do
        begin
            @(posedge clk);
        end
        while (!axiResponse.arReady);
        axiRequest.arValid <= 1'b0;
        if (!quick)
        begin
            waitRandom();
        end
        axiRequest.rReady <= 1'b1;
        do
        begin
            @(posedge clk);
        end
        while (!axiResponse.rValid);
        data = axiResponse.rData;
        resp = axiResponse.rResp;
        axiRequest.rReady <= 1'b0;
    endtask

    task automatic writeBlock(input string name, input logic [7:0] base, input block_t value);
        axiResp_t resp;
        for (int w = 0; w < 4; w++)
        begin
            writeReg(base + 8'(4 * w), value[4*w +: 4], 4'hf, 1'b0, resp);
            compareResp($sformatf("%s write word %0d at %h", name, w, base), RespOkay, resp);
        end
    endtask

    task automatic readBlock(input string name, input logic [7:0] base, output block_t value);
        axiResp_t resp;
        word_t    data;
        for (int w = 0; w < 4; w++)
        begin
            readReg(base + 8'(4 * w), 1'b0, data, resp);
            compareResp($sformatf("%s read word %0d at %h", name, w, base), RespOkay, resp);
            value[4*w +: 4] = data;
        end
    endtask

    // malformed and read-only accesses are run once on an idle peripheral
    task automatic checkBadAccesses();
        axiResp_t resp;
        word_t    data;
        writeReg(RegStatus, 32'h0000_0003, 4'hf, 1'b0, resp);
        compareResp("write to status", RespSlvErr, resp);
        writeReg(RegCipher0, 32'h1234_5678, 4'hf, 1'b0, resp);
        compareResp("write to cipher word 0", RespSlvErr, resp);
        writeReg(RegCipher3, 32'h1234_5678, 4'hf, 1'b0, resp);
        compareResp("write to cipher word 3", RespSlvErr, resp);
        writeReg(RegKey0, 32'hdead_beef, 4'b0011, 1'b0, resp);
        compareResp("partial strobe key write", RespSlvErr, resp);
        readReg(RegKey0, 1'b0, data, resp);
        compareResp("key word 0 after partial write", RespOkay, resp);
        compareWord("key word 0 after partial write", 32'h0, data);
        readReg(8'h40, 1'b0, data, resp);
        compareResp("unmapped read at 40", RespSlvErr, resp);
        compareWord("unmapped read data at 40", 32'h0, data);
        readReg(8'h28, 1'b0, data, resp);
        compareResp("unmapped read at 28", RespSlvErr, resp);
        compareWord("unmapped read data at 28", 32'h0, data);
    endtask

    task automatic runVector(input int i);
        string    name;
        block_t   readBack;
        word_t    status;
        axiResp_t resp;
        name = testNames[i];

        // consecutive vectors that share a key reuse the loaded key register
        if (i == 0 || testKeys[i] != testKeys[i-1])
        begin
            writeBlock({name, " key"}, RegKey0, testKeys[i]);
        end
        writeBlock({name, " text"}, RegText0, testTexts[i]);
        readBlock({name, " key"}, RegKey0, readBack);
        compareBlock({name, " key readback"}, testKeys[i], readBack);
        readBlock({name, " text"}, RegText0, readBack);
        compareBlock({name, " text readback"}, testTexts[i], readBack);

        // the busy checks run back to back so that the core is still running
        writeReg(RegCommand, 32'h1, 4'hf, 1'b1, resp);
        compareResp({name, " start"}, RespOkay, resp);
        writeReg(RegCommand, 32'h1, 4'hf, 1'b1, resp);
        compareResp({name, " start while busy"}, RespSlvErr, resp);
        writeReg(RegKey2, ~testKeys[i][8 +: 4], 4'hf, 1'b1, resp);
        compareResp({name, " key write while busy"}, RespSlvErr, resp);
        readReg(RegStatus, 1'b1, status, resp);
        compareResp({name, " status read while busy"}, RespOkay, resp);
        compareWord({name, " status while busy"}, 32'h1, status);

        do
        begin
            readReg(RegStatus, 1'b0, status, resp);
        end
        while (!status[1]);
        compareWord({name, " status when done"}, 32'h2, status);

        readBlock({name, " cipher"}, RegCipher0, readBack);
        compareBlock({name, " ciphertext"}, testCiphers[i], readBack);
    endtask

    initial
    begin
        int          fd;
        string       line;
        string       name;
        logic [127:0] key;
        logic [127:0] text;
        logic [127:0] cipher;
        word_t       status;
        axiResp_t    resp;

        seed       = 32'h47eb_b555;
        numTests   = 0;
        reset      = 1'b1;
        axiRequest = '0;

        fd = $fopen("bench/aes_tests.txt", "r");
        if (fd == 0)
        begin
            $display("Could not open the test vector file bench/aes_tests.txt");
            abortRun();
        end
        while (!$feof(fd))
        begin
            line = "";
            if ($fgets(line, fd) != 0 && line.len() > 0 && line.getc(0) != "#")
            begin
                if ($sscanf(line, "%s %h %h %h", name, key, text, cipher) == 4)
                begin
                    testNames.push_back(name);
                    testKeys.push_back(key);
                    testTexts.push_back(text);
                    testCiphers.push_back(cipher);
                end
            end
        end
        $fclose(fd);
        if (testNames.size() == 0)
        begin
            $display("The test vector file holds no test vectors");
            abortRun();
        end
        numTests = testNames.size();

        repeat (8) @(posedge clk);
        reset <= 1'b0;

        readReg(RegStatus, 1'b0, status, resp);
        compareResp("status after reset", RespOkay, resp);
        compareWord("status after reset", 32'h0, status);
        checkBadAccesses();

        for (int i = 0; i < numTests; i++)
        begin
            runVector(i);
        end

        $display("Verification passed");
        $finish;
    end

    // watchdog sized from the number of vectors in the file
    initial
    begin
        int limit;
        wait (numTests > 0);
        limit = 400 * numTests + 200;
        repeat (limit) @(posedge clk);
        $display("Timeout: the run did not finish within %0d clock cycles", limit);
        abortRun();
    end

endmodule

`default_nettype wire

// ==== bench/AESTop_props.sv ====
/*
 * AXI4-Lite response and core status properties, bound into the register block
 */
`timescale 1ns/100ps
`default_nettype none

`include "aes_macros.svh"

module AESTop_props import AESDefinitions::*; (
    input logic         clk,
    input logic         reset,
    input axiLiteReq_t  axiRequest,
    input axiLiteResp_t axiResponse,
    input aesResult_t   result,
    input logic         start
);

    bHold: assert property (@(posedge clk) disable iff (reset)
        axiResponse.bValid && !axiRequest.bReady
            |=> axiResponse.bValid && $stable(axiResponse.bResp))
        else $error("write response changed before bReady");

    rHold: assert property (@(posedge clk) disable iff (reset)
        axiResponse.rValid && !axiRequest.rReady
            |=> axiResponse.rValid && $stable(axiResponse.rData) && $stable(axiResponse.rResp))
        else $error("read response changed before rReady");

    // a start makes the core busy and clears a previous done on the next cycle
    startClearsDone: assert property (@(posedge clk) disable iff (reset)
        start |=> result.busy && !result.done)
        else $error("core was not busy with done clear the cycle after start");

    // initial key addition plus ten rounds
    doneLatency: assert property (@(posedge clk) disable iff (reset)
        start |-> ##(`AES_CORE_LATENCY) $rose(result.done))
        else $error("done did not rise at the expected cycle after start");

endmodule

bind AESControlRegs AESTop_props props (
    .clk        (clk),
    .reset      (reset),
    .axiRequest (axiRequest),
    .axiResponse(axiResponse),
    .result     (result),
    .start      (start)
);

`default_nettype wire

// ==== src/AESTop.sv ====
/*
 * AES-128 encryption peripheral with an AXI4-Lite register interface
 */
`timescale 1ns/100ps
`default_nettype none

module AESTop import AESDefinitions::*; (
    input  logic         clk,
    input  logic         reset,
    input  axiLiteReq_t  axiRequest,
    output axiLiteResp_t axiResponse
);

    aesJob_t    job;
    aesResult_t result;
    logic       start;

    AESControlRegs controlRegs (
        .clk        (clk),
        .reset      (reset),
        .axiRequest (axiRequest),
        .axiResponse(axiResponse),
        .result     (result),
        .job        (job),
        .start      (start)
    );

    // the key register stays stable while the core is busy
    AESCore core (
        .clk   (clk),
        .reset (reset),
        .start (start),
        .job   (job),
        .result(result)
    );

endmodule

`default_nettype wire

// ==== src/AESControlRegs.sv ====
/*
 * AXI4-Lite register block with key and plaintext registers, command, status and
 * ciphertext readback, and error responses for busy and malformed accesses
 */
`timescale 1ns/100ps
`default_nettype none

`include "aes_macros.svh"

module AESControlRegs import AESDefinitions::*; (
    input  logic         clk,
    input  logic         reset,
    input  axiLiteReq_t  axiRequest,
    output axiLiteResp_t axiResponse,
    input  aesResult_t   result,
    output aesJob_t      job,
    output logic         start
);

    key_t                       keyReg;
    block_t                     textReg;
    logic                       awReady;
    logic                       arReady;
    logic                       bValid;
    logic                       rValid;
    axiResp_t                   bResp;
    axiResp_t                   rResp;
    logic [`AXI_DATA_WIDTH-1:0] rData;
    logic [`AXI_DATA_WIDTH-1:0] readValue;
    logic                       writeFire;
    logic                       readFire;
    logic                       writeError;
    logic                       readError;
    logic                       busy;
    regOffset_t                 writeOffset;
    regOffset_t                 readOffset;
    logic [3:0]                 writeByte;
    logic [3:0]                 readByte;

    // a start still in flight to the core counts as busy
    assign busy        = result.busy | start;
    assign writeFire   = awReady & axiRequest.awValid & axiRequest.wValid;
    assign readFire    = arReady & axiRequest.arValid;
    assign writeOffset = regOffset_t'(axiRequest.awAddr);
    assign readOffset  = regOffset_t'(axiRequest.arAddr);

    // word 0 of a 128-bit register is its first four bytes
    assign writeByte = {axiRequest.awAddr[3:2], 2'b00};
    assign readByte  = {axiRequest.arAddr[3:2], 2'b00};

    always_comb
    begin
        writeError = 1'b0;
        if (axiRequest.wStrb != '1)
        begin
            writeError = 1'b1;
        end
        else
        begin
            case (writeOffset)
                RegKey0, RegKey1, RegKey2, RegKey3,
                RegText0, RegText1, RegText2, RegText3: writeError = busy;
                RegCommand: writeError = busy & axiRequest.wData[0];
                default:    writeError = 1'b1;
            endcase
        end
    end

    always_comb
    begin
        readValue = '0;
        readError = 1'b0;
        case (readOffset)
            RegKey0, RegKey1, RegKey2, RegKey3: readValue = keyReg[readByte +: 4];
            RegText0, RegText1, RegText2, RegText3: readValue = textReg[readByte +: 4];
            RegCommand: readValue = '0;
            RegStatus:
            begin
                readValue[0] = result.busy;
                readValue[1] = result.done;
            end
            RegCipher0, RegCipher1, RegCipher2, RegCipher3:
                readValue = result.ciphertext[readByte +: 4];
            default: readError = 1'b1;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            awReady <= 1'b0;
            arReady <= 1'b0;
            bValid  <= 1'b0;
            rValid  <= 1'b0;
            bResp   <= RespOkay;
            rResp   <= RespOkay;
            rData   <= '0;
            start   <= 1'b0;
            keyReg  <= '0;
            textReg <= '0;
        end
        else
        begin
            // ready is a single-cycle pulse that is held off while a response waits
            awReady <= ~awReady & axiRequest.awValid & axiRequest.wValid & ~bValid;
            arReady <= ~arReady & axiRequest.arValid & ~rValid;
            start   <= 1'b0;

            if (writeFire)
            begin
                bValid <= 1'b1;
                bResp  <= writeError ? RespSlvErr : RespOkay;
                if (!writeError)
                begin
                    case (writeOffset)
                        RegKey0, RegKey1, RegKey2, RegKey3:
                            keyReg[writeByte +: 4] <= axiRequest.wData;
                        RegText0, RegText1, RegText2, RegText3:
                            textReg[writeByte +: 4] <= axiRequest.wData;
                        RegCommand: start <= axiRequest.wData[0];
                        default: ;
                    endcase
                end
            end
            else if (bValid && axiRequest.bReady)
            begin
                bValid <= 1'b0;
            end

            if (readFire)
            begin
                rValid <= 1'b1;
                rResp  <= readError ? RespSlvErr : RespOkay;
                rData  <= readValue;
            end
            else if (rValid && axiRequest.rReady)
            begin
                rValid <= 1'b0;
            end
        end
    end

    assign axiResponse.awReady = awReady;
    assign axiResponse.wReady  = awReady;
    assign axiResponse.bResp   = bResp;
    assign axiResponse.bValid  = bValid;
    assign axiResponse.arReady = arReady;
    assign axiResponse.rData   = rData;
    assign axiResponse.rResp   = rResp;
    assign axiResponse.rValid  = rValid;

    assign job.key       = keyReg;
    assign job.plaintext = textReg;

endmodule

`default_nettype wire

// ==== src/AESCore.sv ====
/*
 * iterative AES-128 encryption engine, one cipher round per clock
 */
`timescale 1ns/100ps
`default_nettype none

`include "aes_macros.svh"

module AESCore import AESDefinitions::*; (
    input  logic       clk,
    input  logic       reset,
    input  logic       start,
    input  aesJob_t    job,
    output aesResult_t result
);

    coreState_t coreState;
    logic [3:0] round;
    logic       running;
    logic       finalRound;
    logic       keyInUse;
    block_t     cipherState;
    block_t     roundOut;
    roundKeys_t roundKeys;

    assign running    = (coreState == StateRun);
    assign finalRound = (round == 4'(`AES_NUM_ROUNDS));
    assign keyInUse   = running | start;

    ExpandKey expandKey (
        .validInput(keyInUse),
        .key       (job.key),
        .roundKeys (roundKeys)
    );

    EncryptRound encryptRound (
        .stateIn   (cipherState),
        .roundKey  (roundKeys[round]),
        .finalRound(finalRound),
        .stateOut  (roundOut)
    );

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            coreState   <= StateIdle;
            round       <= '0;
            cipherState <= '0;
        end
        else
        begin
            case (coreState)
                StateIdle, StateDone:
                begin
                    // initial AddRoundKey happens in the start cycle
                    if (start)
                    begin
                        coreState   <= StateRun;
                        round       <= 4'd1;
                        cipherState <= job.plaintext ^ roundKeys[0];
                    end
                end
                StateRun:
                begin
                    cipherState <= roundOut;
                    if (finalRound)
                    begin
                        coreState <= StateDone;
                        round     <= '0;
                    end
                    else
                    begin
                        round <= round + 4'd1;
                    end
                end
                default:
                begin
                    coreState <= StateIdle;
                end
            endcase
        end
    end

    assign result.ciphertext = cipherState;
    assign result.busy       = running;
    assign result.done       = (coreState == StateDone);

endmodule

`default_nettype wire

// ==== src/EncryptRound.sv ====
/*
 * one AES cipher round applying SubBytes, ShiftRows, MixColumns and AddRoundKey
 */
`timescale 1ns/100ps
`default_nettype none

module EncryptRound import AESDefinitions::*; (
    input  block_t stateIn,
    input  block_t roundKey,
    input  logic   finalRound,
    output block_t stateOut
);

    block_t subBytes;
    block_t shiftRows;
    block_t mixColumns;

    for (genvar i = 0; i < 16; i++)
    begin : gSbox
        SubstituteByte sbox (
            .in (stateIn[i]),
            .out(subBytes[i])
        );
    end

    // byte index is row + 4 * column and row r rotates left by r columns
    always_comb
    begin
        for (int c = 0; c < 4; c++)
        begin
            for (int r = 0; r < 4; r++)
            begin
                shiftRows[4*c + r] = subBytes[4*((c + r) % 4) + r];
            end
        end
    end

    always_comb
    begin
        byte_t a0;
        byte_t a1;
        byte_t a2;
        byte_t a3;
        for (int c = 0; c < 4; c++)
        begin
            a0 = shiftRows[4*c];
            a1 = shiftRows[4*c + 1];
            a2 = shiftRows[4*c + 2];
            a3 = shiftRows[4*c + 3];
            // column times {02 03 01 01} circulant
            mixColumns[4*c]     = xtime(a0) ^ xtime(a1) ^ a1 ^ a2 ^ a3;
            mixColumns[4*c + 1] = a0 ^ xtime(a1) ^ xtime(a2) ^ a2 ^ a3;
            mixColumns[4*c + 2] = a0 ^ a1 ^ xtime(a2) ^ xtime(a3) ^ a3;
            mixColumns[4*c + 3] = xtime(a0) ^ a0 ^ a1 ^ a2 ^ xtime(a3);
        end
    end

    // the last round of AES has no MixColumns
    assign stateOut = (finalRound ? shiftRows : mixColumns) ^ roundKey;

endmodule

`default_nettype wire

// ==== src/ExpandKey.sv ====
/*
 * AES-128 key schedule, producing all eleven round keys combinationally
 */
`timescale 1ns/100ps
`default_nettype none

`include "aes_macros.svh"

module ExpandKey import AESDefinitions::*; (
    input  logic       validInput,
    input  key_t       key,
    output roundKeys_t roundKeys
);

    typedef byte_t [0:3] keyWord_t;
    typedef keyWord_t [0:3] keyBlock_t;

    // entry 0 is never applied, step r uses entry r
    localparam byte_t RCON [0:`AES_NUM_ROUNDS] = '{
        8'h8d, 8'h01, 8'h02, 8'h04, 8'h08, 8'h10,
        8'h20, 8'h40, 8'h80, 8'h1b, 8'h36
    };

    keyBlock_t keyBlocks [0:`AES_NUM_ROUNDS];

    assign keyBlocks[0] = key;

    for (genvar r = 1; r <= `AES_NUM_ROUNDS; r++)
    begin : gStep
        keyWord_t rotWord;
        keyWord_t subWord;

        // RotWord on the last word of the previous block
        assign rotWord = {keyBlocks[r-1][3][1:3], keyBlocks[r-1][3][0]};

        for (genvar b = 0; b < 4; b++)
        begin : gSbox
            SubstituteByte sbox (
                .in (rotWord[b]),
                .out(subWord[b])
            );
        end

        assign keyBlocks[r][0] = keyBlocks[r-1][0] ^ subWord ^ {RCON[r], 24'h000000};

        // the remaining words chain through the previous block
        for (genvar w = 1; w < 4; w++)
        begin : gChain
            assign keyBlocks[r][w] = keyBlocks[r][w-1] ^ keyBlocks[r-1][w];
        end
    end

    for (genvar r = 0; r <= `AES_NUM_ROUNDS; r++)
    begin : gOut
        assign roundKeys[r] = keyBlocks[r];
    end

    always_comb
    begin
        keyKnownCheck: assert ((validInput !== 1'b1) || !$isunknown(key))
            else $error("key has unknown bits while it is in use");
    end

endmodule

`default_nettype wire

// ==== src/SubstituteByte.sv ====
/*
 * AES S-box for one byte, built from GF(2^8) inversion and the affine map
 */
`timescale 1ns/100ps
`default_nettype none

module SubstituteByte import AESDefinitions::*; (
    input  byte_t in,
    output byte_t out
);

    byte_t inverse;

    function automatic byte_t gfMultiply(input byte_t a, input byte_t b);
        byte_t product;
        byte_t multiple;
        product  = 8'h00;
        multiple = a;
        for (int i = 0; i < 8; i++)
        begin
            if (b[i])
            begin
                product = product ^ multiple;
            end
            multiple = xtime(multiple);
        end
        return product;
    endfunction

    // a^254 = a^2 * a^4 * ... * a^128, which also maps zero to zero
    function automatic byte_t gfInverse(input byte_t a);
        byte_t power;
        byte_t result;
        power  = a;
        result = 8'h01;
        for (int i = 1; i < 8; i++)
        begin
            power  = gfMultiply(power, power);
            result = gfMultiply(result, power);
        end
        return result;
    endfunction

    assign inverse = gfInverse(in);

    // affine map as the xor of four left rotations plus the constant 0x63
    assign out = inverse
               ^ {inverse[6:0], inverse[7]}
               ^ {inverse[5:0], inverse[7:6]}
               ^ {inverse[4:0], inverse[7:5]}
               ^ {inverse[3:0], inverse[7:4]}
               ^ 8'h63;

endmodule

`default_nettype wire

// ==== src/AESDefinitions.sv ====
/*
 * AES types shared by the register block, the key schedule and the cipher core
 */
`default_nettype none

`include "aes_macros.svh"

package AESDefinitions;

    typedef logic [7:0] byte_t;

    // sixteen bytes in column order, byte 0 sits in the most significant position
    typedef byte_t [0:`AES_BLOCK_BITS/8-1] block_t;
    typedef byte_t [0:`AES_BLOCK_BITS/8-1] key_t;
    typedef block_t [0:`AES_NUM_ROUNDS] roundKeys_t;

    typedef enum logic [1:0] {
        RespOkay   = 2'b00,
        RespSlvErr = 2'b10
    } axiResp_t;

    typedef struct packed {
        logic [`AXI_ADDR_WIDTH-1:0] awAddr;
        logic                       awValid;
        logic [`AXI_DATA_WIDTH-1:0] wData;
        logic [`AXI_STRB_WIDTH-1:0] wStrb;
        logic                       wValid;
        logic                       bReady;
        logic [`AXI_ADDR_WIDTH-1:0] arAddr;
        logic                       arValid;
        logic                       rReady;
    } axiLiteReq_t;

    typedef struct packed {
        logic                       awReady;
        logic                       wReady;
        axiResp_t                   bResp;
        logic                       bValid;
        logic                       arReady;
        logic [`AXI_DATA_WIDTH-1:0] rData;
        axiResp_t                   rResp;
        logic                       rValid;
    } axiLiteResp_t;

    typedef struct packed {
        key_t   key;
        block_t plaintext;
    } aesJob_t;

    typedef struct packed {
        block_t ciphertext;
        logic   busy;
        logic   done;
    } aesResult_t;

    typedef enum logic [1:0] {
        StateIdle,
        StateRun,
        StateDone
    } coreState_t;

    typedef enum logic [`AXI_ADDR_WIDTH-1:0] {
        RegKey0    = 8'h00,
        RegKey1    = 8'h04,
        RegKey2    = 8'h08,
        RegKey3    = 8'h0C,
        RegText0   = 8'h10,
        RegText1   = 8'h14,
        RegText2   = 8'h18,
        RegText3   = 8'h1C,
        RegCommand = 8'h20,
        RegStatus  = 8'h24,
        RegCipher0 = 8'h30,
        RegCipher1 = 8'h34,
        RegCipher2 = 8'h38,
        RegCipher3 = 8'h3C
    } regOffset_t;

    // multiply by x in GF(2^8), reduced by the AES polynomial
    function automatic byte_t xtime(input byte_t value);
        return {value[6:0], 1'b0} ^ (value[7] ? 8'h1b : 8'h00);
    endfunction

endpackage

`default_nettype wire

// ==== src/aes_macros.svh ====
/*
 * AES peripheral constants for the cipher round count, block size and AXI4-Lite widths
 */
`ifndef AES_MACROS_SVH
`define AES_MACROS_SVH

// AES-128 runs ten rounds after the initial key addition
`define AES_NUM_ROUNDS 10
`define AES_BLOCK_BITS 128

// cycles from the core start pulse to done
`define AES_CORE_LATENCY (`AES_NUM_ROUNDS + 1)

`define AXI_ADDR_WIDTH 8
`define AXI_DATA_WIDTH 32
`define AXI_STRB_WIDTH (`AXI_DATA_WIDTH / 8)

`endif
